// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
verilator --binary --timing --assert -f sources.f --top-module dashboard_tb -o dashboard_sim \
    && ./obj_dir/dashboard_sim | grep -F "** PASS **" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// ==== sources.f ====
src/car_pkg.sv
src/engine_rpm.sv
src/redline_lamp.sv
src/road_speed.sv
src/odometer.sv
src/dash_axil_regs.sv
src/dashboard_top.sv
verif/dashboard_assert.sv
verif/dashboard_checker.sv
verif/dashboard_tb.sv

// ==== src/car_pkg.sv ====
package car_pkg;

    //////////////////////////////
    // Engine
    //////////////////////////////
    localparam int RPM_W = 14;
    localparam logic [RPM_W-1:0] RPM_IDLE       = 14'd1000;
    localparam logic [RPM_W-1:0] RPM_MAX        = 14'd11000;
    localparam logic [RPM_W-1:0] RPM_SHIFT_DROP = 14'd5500;
    localparam logic [RPM_W-1:0] NEUTRAL_DECAY  = 14'd10;
    localparam logic [RPM_W-1:0] REDLINE_ON     = 14'd10500;
    localparam logic [RPM_W-1:0] REDLINE_OFF    = 14'd10000;
    localparam int GEAR_W = 2;

    // Road speed, km/h
    localparam int SPEED_W = 8;
    // Gear ratios in 1/1024 units
    localparam logic [4:0] RATIO_G1 = 5'd4;
    localparam logic [4:0] RATIO_G2 = 5'd9;
    localparam logic [4:0] RATIO_G3 = 5'd16;
    localparam int RATIO_SHIFT = 10;

    // Distance
    localparam int ODO_W     = 32;
    localparam int ODO_SHIFT = 8;

    //////////////////////////////
    // Register map
    //////////////////////////////
    localparam int AXI_ADDR_W = 5;
    localparam int AXI_DATA_W = 32;
    localparam logic [AXI_ADDR_W-1:0] REG_STATUS = 5'h00;
    localparam logic [AXI_ADDR_W-1:0] REG_RPM    = 5'h04;
    localparam logic [AXI_ADDR_W-1:0] REG_SPEED  = 5'h08;
    localparam logic [AXI_ADDR_W-1:0] REG_ODO    = 5'h0C;
    localparam logic [AXI_ADDR_W-1:0] REG_CTRL   = 5'h10;
    localparam int CTRL_ENGINE_RST = 0;
    localparam int CTRL_ODO_CLR    = 1;
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_DECERR = 2'b11;

endpackage

// ==== src/dash_axil_regs.sv ====
`timescale 1ns/1ps

module dash_axil_regs (
    input  logic                           clk100Hz,
    input  logic                           rst_n,
    // AXI write side
    input  logic                           awvalid,
    output logic                           awready,
    input  logic [car_pkg::AXI_ADDR_W-1:0] awaddr,
    input  logic                           wvalid,
    output logic                           wready,
    input  logic [car_pkg::AXI_DATA_W-1:0] wdata,
    input  logic [3:0]                     wstrb,
    output logic                           bvalid,
    input  logic                           bready,
    output logic [1:0]                     bresp,
    // AXI read side
    input  logic                           arvalid,
    output logic                           arready,
    input  logic [car_pkg::AXI_ADDR_W-1:0] araddr,
    output logic                           rvalid,
    input  logic                           rready,
    output logic [car_pkg::AXI_DATA_W-1:0] rdata,
    output logic [1:0]                     rresp,
    // Dashboard values
    input  logic [car_pkg::RPM_W-1:0]      rpm,
    input  logic [car_pkg::GEAR_W-1:0]     gear_engaged,
    input  logic                           redline,
    input  logic [car_pkg::SPEED_W-1:0]    speed,
    input  logic [car_pkg::ODO_W-1:0]      distance,
    // Control pulses
    output logic                           engine_rst_pulse,
    output logic                           odo_clr_pulse
);

    logic                           wr_fire;
    logic                           ctrl_hit;
    logic                           rd_fire;
    logic [car_pkg::AXI_DATA_W-1:0] rd_data;
    logic [1:0]                     rd_resp;

    //////////////////////////////
    // Write channel
    //////////////////////////////
    // Address and data taken together, never while B is outstanding
    assign wr_fire = awvalid && wvalid && !bvalid;
    assign awready = wr_fire;
    assign wready  = wr_fire;
    assign ctrl_hit = wr_fire && (awaddr == car_pkg::REG_CTRL) && wstrb[0];

    // Every write completes OKAY, only CTRL has an effect
    assign bresp = car_pkg::RESP_OKAY;

    always_ff @(posedge clk100Hz) begin
        if (!rst_n) begin
            bvalid           <= 1'b0;
            engine_rst_pulse <= 1'b0;
            odo_clr_pulse    <= 1'b0;
        end else begin
            engine_rst_pulse <= ctrl_hit && wdata[car_pkg::CTRL_ENGINE_RST];
            odo_clr_pulse    <= ctrl_hit && wdata[car_pkg::CTRL_ODO_CLR];
            if (wr_fire) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    //////////////////////////////
    // Read channel
    //////////////////////////////
    assign arready = !rvalid;
    assign rd_fire = arvalid && arready;

    // Register decode
    always_comb begin
        rd_data = '0;
        rd_resp = car_pkg::RESP_OKAY;
        case (araddr)
            car_pkg::REG_STATUS: rd_data = {27'd0, redline, 2'd0, gear_engaged};
            car_pkg::REG_RPM: begin
                rd_data = {{(car_pkg::AXI_DATA_W - car_pkg::RPM_W){1'b0}}, rpm};
            end
            car_pkg::REG_SPEED: begin
                rd_data = {{(car_pkg::AXI_DATA_W - car_pkg::SPEED_W){1'b0}}, speed};
            end
            car_pkg::REG_ODO:  rd_data = distance;
            car_pkg::REG_CTRL: rd_data = '0;   // write-only
            default:           rd_resp = car_pkg::RESP_DECERR;
        endcase
    end

    always_ff @(posedge clk100Hz) begin
        if (!rst_n) begin
            rvalid <= 1'b0;
        end else if (rd_fire) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    // Data captured on the AR handshake
    always_ff @(posedge clk100Hz) begin
        if (rd_fire) begin
            rdata <= rd_data;
            rresp <= rd_resp;
        end
    end

endmodule

// ==== src/dashboard_top.sv ====
`timescale 1ns/1ps

module dashboard_top (
    input  logic                           clk100Hz,
    input  logic                           rst_n,
    input  logic [car_pkg::GEAR_W-1:0]     gear_in,
    input  logic                           gas_key,
    input  logic                           awvalid,
    output logic                           awready,
    input  logic [car_pkg::AXI_ADDR_W-1:0] awaddr,
    input  logic                           wvalid,
    output logic                           wready,
    input  logic [car_pkg::AXI_DATA_W-1:0] wdata,
    input  logic [3:0]                     wstrb,
    output logic                           bvalid,
    input  logic                           bready,
    output logic [1:0]                     bresp,
    input  logic                           arvalid,
    output logic                           arready,
    input  logic [car_pkg::AXI_ADDR_W-1:0] araddr,
    output logic                           rvalid,
    input  logic                           rready,
    output logic [car_pkg::AXI_DATA_W-1:0] rdata,
    output logic [1:0]                     rresp,
    output logic                           redline
);

    logic [car_pkg::RPM_W-1:0]   rpm;
    logic [car_pkg::GEAR_W-1:0]  gear_engaged;
    logic [car_pkg::SPEED_W-1:0] speed;
    logic [car_pkg::ODO_W-1:0]   distance;
    logic                        engine_rst_pulse;
    logic                        odo_clr_pulse;

    engine_rpm engine_rpm_i (
        .clk100Hz         (clk100Hz),
        .rst_n            (rst_n),
        .engine_rst_pulse (engine_rst_pulse),
        .gear_in          (gear_in),
        .gas_key          (gas_key),
        .rpm              (rpm),
        .gear_engaged     (gear_engaged)
    );

    redline_lamp redline_lamp_i (
        .clk100Hz (clk100Hz),
        .rst_n    (rst_n),
        .rpm      (rpm),
        .redline  (redline)
    );

    road_speed road_speed_i (
        .clk100Hz     (clk100Hz),
        .rst_n        (rst_n),
        .rpm          (rpm),
        .gear_engaged (gear_engaged),
        .speed        (speed)
    );

    odometer odometer_i (
        .clk100Hz      (clk100Hz),
        .rst_n         (rst_n),
        .odo_clr_pulse (odo_clr_pulse),
        .speed         (speed),
        .distance      (distance)
    );

    // Host register window
    dash_axil_regs dash_axil_regs_i (
        .clk100Hz         (clk100Hz),
        .rst_n            (rst_n),
        .awvalid          (awvalid),
        .awready          (awready),
        .awaddr           (awaddr),
        .wvalid           (wvalid),
        .wready           (wready),
        .wdata            (wdata),
        .wstrb            (wstrb),
        .bvalid           (bvalid),
        .bready           (bready),
        .bresp            (bresp),
        .arvalid          (arvalid),
        .arready          (arready),
        .araddr           (araddr),
        .rvalid           (rvalid),
        .rready           (rready),
        .rdata            (rdata),
        .rresp            (rresp),
        .rpm              (rpm),
        .gear_engaged     (gear_engaged),
        .redline          (redline),
        .speed            (speed),
        .distance         (distance),
        .engine_rst_pulse (engine_rst_pulse),
        .odo_clr_pulse    (odo_clr_pulse)
    );

endmodule

// ==== src/engine_rpm.sv ====
`timescale 1ns/1ps

module engine_rpm (
    input  logic                       clk100Hz,
    input  logic                       rst_n,
    input  logic                       engine_rst_pulse,
    input  logic [car_pkg::GEAR_W-1:0] gear_in,
    input  logic                       gas_key,
    output logic [car_pkg::RPM_W-1:0]  rpm,
    output logic [car_pkg::GEAR_W-1:0] gear_engaged
);

    //////////////////////////////
    // Acceleration step table
    //////////////////////////////
    localparam int STEP_W  = 6;
    localparam int N_BANDS = 7;

    // Upper edge of each band, last band is open
    localparam logic [car_pkg::RPM_W-1:0] BAND_TOP [N_BANDS-1] = '{
        14'd2000, 14'd3000, 14'd4000, 14'd5000, 14'd7000, 14'd9000
    };

    localparam logic [STEP_W-1:0] STEP_NEUTRAL [N_BANDS] = '{
        6'd26, 6'd27, 6'd31, 6'd34, 6'd36, 6'd36, 6'd36
    };
    localparam logic [STEP_W-1:0] STEP_G1 [N_BANDS] = '{
        6'd7, 6'd7, 6'd8, 6'd10, 6'd15, 6'd16, 6'd17
    };
    // Second and third gear share one row
    localparam logic [STEP_W-1:0] STEP_G23 [N_BANDS] = '{
        6'd2, 6'd2, 6'd4, 6'd8, 6'd12, 6'd13, 6'd13
    };

    // Below this a shift lands on idle
    localparam logic [car_pkg::RPM_W-1:0] SHIFT_FLOOR =
        car_pkg::RPM_IDLE + car_pkg::RPM_SHIFT_DROP;

    logic [car_pkg::RPM_W-1:0]  rpm_nxt;
    logic [car_pkg::GEAR_W-1:0] gear_nxt;
    logic [STEP_W-1:0]          step;
    logic [car_pkg::RPM_W:0]    rpm_sum;

    function automatic int band_of(input logic [car_pkg::RPM_W-1:0] r);
        int b;
        b = N_BANDS - 1;
        for (int i = N_BANDS - 2; i >= 0; i--) begin
            if (r <= BAND_TOP[i]) begin
                b = i;
            end
        end
        return b;
    endfunction

    function automatic logic [STEP_W-1:0] step_of(
        input logic [car_pkg::RPM_W-1:0]  r,
        input logic [car_pkg::GEAR_W-1:0] g
    );
        int b;
        b = band_of(r);
        case (g)
            2'd0:    return STEP_NEUTRAL[b];
            2'd1:    return STEP_G1[b];
            default: return STEP_G23[b];
        endcase
    endfunction

    always_comb begin
        step     = step_of(rpm, gear_engaged);
        rpm_sum  = {1'b0, rpm} + {{(car_pkg::RPM_W + 1 - STEP_W){1'b0}}, step};
        rpm_nxt  = rpm;
        gear_nxt = gear_engaged;

        if (gear_in != gear_engaged) begin
            // Shift takes priority over gas
            gear_nxt = gear_in;
            if (rpm < SHIFT_FLOOR) begin
                rpm_nxt = car_pkg::RPM_IDLE;
            end else begin
                rpm_nxt = rpm - car_pkg::RPM_SHIFT_DROP;
            end
        end else if (gas_key) begin
            if (rpm < car_pkg::RPM_IDLE) begin
                rpm_nxt = car_pkg::RPM_IDLE;
            end else if (rpm_sum > {1'b0, car_pkg::RPM_MAX}) begin
                rpm_nxt = car_pkg::RPM_MAX;
            end else begin
                rpm_nxt = rpm_sum[car_pkg::RPM_W-1:0];
            end
        end else if (rpm > car_pkg::RPM_IDLE) begin
            rpm_nxt = rpm - car_pkg::NEUTRAL_DECAY;
        end else if (gear_engaged == '0) begin
            // Engine stalls out in neutral
            rpm_nxt = '0;
        end else begin
            rpm_nxt = car_pkg::RPM_IDLE;
        end
    end

    always_ff @(posedge clk100Hz) begin
        if (!rst_n || engine_rst_pulse) begin
            rpm          <= '0;
            gear_engaged <= '0;
        end else begin
            rpm          <= rpm_nxt;
            gear_engaged <= gear_nxt;
        end
    end

endmodule

// ==== src/odometer.sv ====
`timescale 1ns/1ps

module odometer (
    input  logic                        clk100Hz,
    input  logic                        rst_n,
    input  logic                        odo_clr_pulse,
    input  logic [car_pkg::SPEED_W-1:0] speed,
    output logic [car_pkg::ODO_W-1:0]   distance
);

    logic [car_pkg::ODO_W-1:0] acc;

    //////////////////////////////
    // Accumulator
    //////////////////////////////
    // Wraps freely, clear wins over the add
    always_ff @(posedge clk100Hz) begin
        if (!rst_n || odo_clr_pulse) begin
            acc <= '0;
        end else begin
            acc <= acc + {{(car_pkg::ODO_W - car_pkg::SPEED_W){1'b0}}, speed};
        end
    end

    // Reported in coarse units
    assign distance = acc >> car_pkg::ODO_SHIFT;

endmodule

// ==== src/redline_lamp.sv ====
`timescale 1ns/1ps

module redline_lamp (
    input  logic                      clk100Hz,
    input  logic                      rst_n,
    input  logic [car_pkg::RPM_W-1:0] rpm,
    output logic                      redline
);

    logic lamp_nxt;

    // Hysteresis band between OFF and ON keeps the last state
    always_comb begin
        lamp_nxt = redline;
        if (rpm >= car_pkg::REDLINE_ON) begin
            lamp_nxt = 1'b1;
        end else if (rpm < car_pkg::REDLINE_OFF) begin
            lamp_nxt = 1'b0;
        end
    end

    always_ff @(posedge clk100Hz) begin
        if (!rst_n) begin
            redline <= 1'b0;
        end else begin
            redline <= lamp_nxt;
        end
    end

endmodule

// ==== src/road_speed.sv ====
`timescale 1ns/1ps

module road_speed (
    input  logic                       clk100Hz,
    input  logic                       rst_n,
    input  logic [car_pkg::RPM_W-1:0]  rpm,
    input  logic [car_pkg::GEAR_W-1:0] gear_engaged,
    output logic [car_pkg::SPEED_W-1:0] speed
);

    localparam int PROD_W = car_pkg::RPM_W + 5;

    logic [4:0]        ratio;
    logic [PROD_W-1:0] product;

    // Ratio of the engaged gear
    always_comb begin
        case (gear_engaged)
            2'd1:    ratio = car_pkg::RATIO_G1;
            2'd2:    ratio = car_pkg::RATIO_G2;
            2'd3:    ratio = car_pkg::RATIO_G3;
            default: ratio = 5'd0;
        endcase
    end

    assign product = {5'd0, rpm} * {{(PROD_W - 5){1'b0}}, ratio};

    // Top gear at the limiter gives 171 km/h, fits in SPEED_W
    always_ff @(posedge clk100Hz) begin
        if (!rst_n) begin
            speed <= '0;
        end else begin
            speed <= product[car_pkg::RATIO_SHIFT +: car_pkg::SPEED_W];
        end
    end

endmodule

// ==== verif/dashboard_assert.sv ====
`timescale 1ns/1ps

module dashboard_assert (
    input logic clk100Hz,
    input logic rst_n,
    input logic bvalid,
    input logic bready,
    input logic rvalid,
    input logic rready,
    input logic engine_rst_pulse,
    input logic odo_clr_pulse
);

    // Response valids hold until taken
    b_hold: assert property (@(posedge clk100Hz) disable iff (!rst_n)
        bvalid && !bready |=> bvalid) else $error("BVALID dropped before BREADY");
    r_hold: assert property (@(posedge clk100Hz) disable iff (!rst_n)
        rvalid && !rready |=> rvalid) else $error("RVALID dropped before RREADY");

    rst_idle: assert property (@(posedge clk100Hz)
        !rst_n |=> !bvalid && !rvalid) else $error("Response valid set out of reset");

    // Control pulses are single cycle
    erst_one: assert property (@(posedge clk100Hz) disable iff (!rst_n)
        engine_rst_pulse |=> !engine_rst_pulse) else $error("Engine restart pulse too long");
    oclr_one: assert property (@(posedge clk100Hz) disable iff (!rst_n)
        odo_clr_pulse |=> !odo_clr_pulse) else $error("Odometer clear pulse too long");

endmodule

bind dash_axil_regs dashboard_assert dashboard_assert_i (
    .clk100Hz         (clk100Hz),
    .rst_n            (rst_n),
    .bvalid           (bvalid),
    .bready           (bready),
    .rvalid           (rvalid),
    .rready           (rready),
    .engine_rst_pulse (engine_rst_pulse),
    .odo_clr_pulse    (odo_clr_pulse)
);

// ==== verif/dashboard_checker.sv ====
`timescale 1ns/1ps

module dashboard_checker (
    input  logic        clk100Hz,
    input  logic        rst_n,
    input  logic [1:0]  gear_in,
    input  logic        gas_key,
    input  logic        awvalid,
    input  logic        awready,
    input  logic [4:0]  awaddr,
    input  logic        wvalid,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        bvalid,
    input  logic        bready,
    input  logic [1:0]  bresp,
    input  logic        arvalid,
    input  logic        arready,
    input  logic [4:0]  araddr,
    input  logic        rvalid,
    input  logic        rready,
    input  logic [31:0] rdata,
    input  logic [1:0]  rresp,
    input  logic        redline,
    input  int          test_num,
    output int          err_cnt,
    output int          chk_cnt
);

    // Step per clock, columns neutral, first, second and third
    int step_tbl [7][3] = '{
        '{26, 7, 2}, '{27, 7, 2}, '{31, 8, 4}, '{34, 10, 8},
        '{36, 15, 12}, '{36, 16, 13}, '{36, 17, 13}
    };

    //////////////////////////////
    // Reference model state
    //////////////////////////////
    int          m_rpm = 0;
    int          m_gear = 0;
    int          m_speed = 0;
    logic        m_red = 1'b0;
    logic [31:0] m_acc = '0;
    logic        m_erst = 1'b0;
    logic        m_oclr = 1'b0;
    logic [31:0] exp_data = '0;
    logic [1:0]  exp_resp = '0;
    int          err_mark = 0;
    int          chk_mark = 0;

    initial begin
        err_cnt = 0;
        chk_cnt = 0;
    end

    function automatic int step_for(input int r, input int g);
        int band;
        int col;
        if (r <= 2000) band = 0;
        else if (r <= 3000) band = 1;
        else if (r <= 4000) band = 2;
        else if (r <= 5000) band = 3;
        else if (r <= 7000) band = 4;
        else if (r <= 9000) band = 5;
        else band = 6;
        col = (g > 2) ? 2 : g;
        return step_tbl[band][col];
    endfunction

    function automatic int ratio_for(input int g);
        case (g)
            1:       return 4;
            2:       return 9;
            3:       return 16;
            default: return 0;
        endcase
    endfunction

    task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("[ERROR] %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
        end
    endtask

    always @(posedge clk100Hz) begin
        int   n_rpm;
        int   n_gear;
        int   g_in;
        logic n_red;
        logic wr_ctrl;
        g_in = int'({30'd0, gear_in});
        if (rst_n) begin
            compare("redline pin", {31'd0, redline}, {31'd0, m_red});
            if (bvalid && bready) begin
                compare("bresp", {30'd0, bresp}, 32'd0);
            end
            if (rvalid && rready) begin
                compare("rdata", rdata, exp_data);
                compare("rresp", {30'd0, rresp}, {30'd0, exp_resp});
            end
            // Expected read data frozen at the address handshake
            if (arvalid && arready) begin
                exp_resp = 2'b00;
                case (araddr)
                    5'h00:   exp_data = 32'((m_red ? 16 : 0) + m_gear);
                    5'h04:   exp_data = 32'(m_rpm);
                    5'h08:   exp_data = 32'(m_speed);
                    5'h0C:   exp_data = m_acc >> 8;
                    5'h10:   exp_data = '0;
                    default: begin
                        exp_data = '0;
                        exp_resp = 2'b11;
                    end
                endcase
            end
        end

        //////////////////////////////
        // Next model state
        //////////////////////////////
        wr_ctrl = rst_n && awvalid && wvalid && awready && awaddr == 5'h10 && wstrb[0];
        n_rpm = m_rpm;
        n_gear = m_gear;
        if (g_in != m_gear) begin
            n_gear = g_in;
            n_rpm = (m_rpm - 5500 < 1000) ? 1000 : m_rpm - 5500;
        end else if (gas_key) begin
            if (m_rpm < 1000) begin
                n_rpm = 1000;
            end else begin
                n_rpm = m_rpm + step_for(m_rpm, m_gear);
                if (n_rpm > 11000) n_rpm = 11000;
            end
        end else if (m_rpm > 1000) begin
            n_rpm = m_rpm - 10;
        end else begin
            n_rpm = (m_gear == 0) ? 0 : 1000;
        end
        if (!rst_n || m_erst) begin
            n_rpm = 0;
            n_gear = 0;
        end
        n_red = m_red;
        if (m_rpm >= 10500) n_red = 1'b1;
        else if (m_rpm < 10000) n_red = 1'b0;
        m_acc = (!rst_n || m_oclr) ? 32'd0 : m_acc + 32'(m_speed);
        m_speed = rst_n ? (((m_rpm * ratio_for(m_gear)) >> 10) & 255) : 0;
        m_red = rst_n && n_red;
        m_rpm = n_rpm;
        m_gear = n_gear;
        m_erst = wr_ctrl && wdata[0];
        m_oclr = wr_ctrl && wdata[1];
    end

    always @(test_num) begin
        $display("Test %0d finished: %0d checks, %0d errors",
                 test_num, chk_cnt - chk_mark, err_cnt - err_mark);
        chk_mark = chk_cnt;
        err_mark = err_cnt;
    end

endmodule

// ==== verif/dashboard_tb.sv ====
`timescale 1ns/1ps

module dashboard_tb;

    localparam int N_ROWS = 11;

    // Gear, gas, cycles and CTRL write data per row
    // Zero CTRL data means no write
    localparam logic [1:0]  ROW_GEAR [N_ROWS] = '{0, 0, 0, 0, 1, 2, 3, 3, 3, 3, 0};
    localparam logic        ROW_GAS [N_ROWS]  = '{0, 1, 0, 0, 1, 1, 1, 0, 0, 1, 0};
    localparam int          ROW_CYC [N_ROWS]  = '{5, 400, 60, 100, 200, 300, 300, 20, 20, 50, 300};
    localparam logic [31:0] ROW_CTRL [N_ROWS] = '{0, 0, 0, 0, 0, 0, 0, 0, 2, 1, 0};

    logic        clk100Hz = 1'b0;
    logic        rst_n;
    logic [1:0]  gear_in;
    logic        gas_key;
    logic        awvalid, awready, wvalid, wready, bvalid, bready;
    logic [4:0]  awaddr, araddr;
    logic [31:0] wdata, rdata;
    logic [3:0]  wstrb;
    logic [1:0]  bresp, rresp;
    logic        arvalid, arready, rvalid, rready;
    logic        redline;
    int          test_num = 0;
    int          err_cnt;
    int          chk_cnt;
    int          cycles = 0;
    int          limit = 0;

    always #20 clk100Hz = ~clk100Hz;

    dashboard_top dashboard_top_i (
        .clk100Hz (clk100Hz), .rst_n (rst_n), .gear_in (gear_in), .gas_key (gas_key),
        .awvalid (awvalid), .awready (awready), .awaddr (awaddr),
        .wvalid (wvalid), .wready (wready), .wdata (wdata), .wstrb (wstrb),
        .bvalid (bvalid), .bready (bready), .bresp (bresp),
        .arvalid (arvalid), .arready (arready), .araddr (araddr),
        .rvalid (rvalid), .rready (rready), .rdata (rdata), .rresp (rresp),
        .redline (redline)
    );

    dashboard_checker checker_i (
        .clk100Hz (clk100Hz), .rst_n (rst_n), .gear_in (gear_in), .gas_key (gas_key),
        .awvalid (awvalid), .awready (awready), .awaddr (awaddr),
        .wvalid (wvalid), .wdata (wdata), .wstrb (wstrb),
        .bvalid (bvalid), .bready (bready), .bresp (bresp),
        .arvalid (arvalid), .arready (arready), .araddr (araddr),
        .rvalid (rvalid), .rready (rready), .rdata (rdata), .rresp (rresp),
        .redline (redline), .test_num (test_num), .err_cnt (err_cnt), .chk_cnt (chk_cnt)
    );

    // Both tasks start and end just after a rising edge
    task automatic axi_write(input logic [4:0] addr, input logic [31:0] data);
        awaddr  <= addr;
        wdata   <= data;
        wstrb   <= 4'hF;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        do @(posedge clk100Hz); while (!(awready && wready));
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        bready  <= 1'b1;
        do @(posedge clk100Hz); while (!bvalid);
        bready  <= 1'b0;
    endtask

    task automatic axi_read(input logic [4:0] addr);
        int unsigned delay;
        araddr  <= addr;
        arvalid <= 1'b1;
        do @(posedge clk100Hz); while (!arready);
        arvalid <= 1'b0;
        delay = $urandom % 4;
        repeat (delay) @(posedge clk100Hz);
        rready  <= 1'b1;
        do @(posedge clk100Hz); while (!rvalid);
        rready  <= 1'b0;
    endtask

    always @(posedge clk100Hz) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("Timeout: run did not finish within %0d cycles", limit);
            $display("** FAIL **");
            $finish;
        end
    end

    initial begin
        int unsigned seed;
        int total;
        seed = $urandom(32'he3c385a9);
        rst_n = 1'b0;
        gear_in = '0;
        gas_key = 1'b0;
        {awvalid, wvalid, bready, arvalid, rready} = '0;
        awaddr = '0;
        araddr = '0;
        wdata = '0;
        wstrb = '0;
        total = 0;
        for (int i = 0; i < N_ROWS; i++) total += ROW_CYC[i];
        limit = 2 * total + 200;
        repeat (2) @(posedge clk100Hz);
        rst_n <= 1'b1;

        //////////////////////////////
        // Table driven rows
        //////////////////////////////
        for (int i = 0; i < N_ROWS; i++) begin
            @(posedge clk100Hz);
            gear_in <= ROW_GEAR[i];
            gas_key <= ROW_GAS[i];
            if (ROW_CTRL[i] != 0) begin
                axi_write(car_pkg::REG_CTRL, ROW_CTRL[i]);
                // Gear reads neutral for one cycle after an engine restart
                axi_read(car_pkg::REG_STATUS);
            end
            repeat (ROW_CYC[i]) @(posedge clk100Hz);
            axi_read(car_pkg::REG_RPM);
            axi_read(car_pkg::REG_STATUS);
            axi_read(car_pkg::REG_SPEED);
            axi_read(car_pkg::REG_ODO);
            test_num <= i + 1;
        end

        // Unmapped offsets and the write-only CTRL
        axi_read(5'h14);
        axi_read(5'h1C);
        axi_read(car_pkg::REG_CTRL);
        test_num <= N_ROWS + 1;
        repeat (4) @(posedge clk100Hz);

        $display("Done: %0d tests, %0d checks, %0d errors", test_num, chk_cnt, err_cnt);
        if (err_cnt == 0 && chk_cnt > 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
